// File: rtl/com_pkg.sv
package com_pkg;

    // packet classification seen by the register file and the reply sequencer.
    typedef enum logic [3:0] {
        INIT   = 4'b0000,
        ACK    = 4'b0001,
        NAK    = 4'b0010,
        STL    = 4'b0011,
        DIDX   = 4'b0101,
        DPARAM = 4'b0110,
        DDIDX  = 4'b0111,
        ERROR  = 4'b1111
    } btype_e;

    typedef enum logic [7:0] {
        IDLE = 8'h00,
        WAIT = 8'h01,
        WORK = 8'h02,
        DONE = 8'h03,
        RPID = 8'h04,
        DNUM = 8'h05,
        CRC5 = 8'h06,
        EROR = 8'h10
    } rx_state_e;

    typedef enum logic [1:0] {
        T_IDLE,
        T_SYNC,
        T_PID,
        T_END
    } tx_state_e;

    localparam logic [7:0] PID_SYNC = 8'h01;
    localparam logic [7:0] PID_CMD  = 8'h1E;
    localparam logic [7:0] PID_ACK  = 8'h2D;
    localparam logic [7:0] PID_NAK  = 8'hA5;
    localparam logic [7:0] PID_STL  = 8'hE1;

    // upper nibble of the first data byte.
    localparam logic [3:0] HEAD_DDIDX  = 4'h1;
    localparam logic [3:0] HEAD_DPARAM = 4'h5;
    localparam logic [3:0] HEAD_DIDX   = 4'h9;

    localparam logic [15:0] NLEN = 16'h0002; // length field is two bytes.

    // x^5 + x^2 + 1, register preset to all ones.
    localparam logic [4:0] CRC5_INIT = 5'b11111;
    localparam logic [4:0] CRC5_POLY = 5'b00101;

endpackage

// File: rtl/crc5.sv
`timescale 1ns/1ps

module crc5 (
    input  logic       clk,
    input  logic       rst,
    input  logic       clear,
    input  logic       enable,
    input  logic [7:0] din,
    output logic [7:0] dout
);

    logic [4:0] rem;
    logic [4:0] rem_next;

    // fold one byte, lsb first.
    always_comb begin
        rem_next = rem;
        for (int i = 0; i < 8; i++) begin
            if (din[i] ^ rem_next[4]) begin
                rem_next = {rem_next[3:0], 1'b0} ^ com_pkg::CRC5_POLY;
            end else begin
                rem_next = {rem_next[3:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rem <= com_pkg::CRC5_INIT;
        end else if (clear) begin
            rem <= com_pkg::CRC5_INIT;
        end else if (enable) begin
            rem <= rem_next;
        end
    end

    assign dout = {3'b000, ~rem}; // check byte as sent on the wire.

endmodule

// File: rtl/com_rx.sv
`timescale 1ns/1ps

module com_rx (
    input  logic             clk,
    input  logic             rst,
    input  logic             fd,
    input  logic [7:0]       com_rxd,
    output logic             fs,
    output com_pkg::btype_e  btype,
    output logic [31:0]      data_cmd
);

    com_pkg::rx_state_e state;
    com_pkg::rx_state_e next_state;

    logic [15:0] num;
    logic [3:0]  ram_tlen;
    logic [15:0] len_last;
    logic [15:0] data_last;

    logic [3:0] device_idx;
    logic [3:0] data_idx;
    logic [3:0] freq_samp;
    logic [3:0] filt_up;
    logic [3:0] filt_low;

    logic       head_byte;
    logic       param_byte;
    logic       crc_en;
    logic       crc_clr;
    logic       crc_ok;
    logic [7:0] crc_out;

    assign len_last   = com_pkg::NLEN - 16'd1;
    assign data_last  = {12'h000, ram_tlen} - 16'd1;
    assign head_byte  = (state == com_pkg::WORK) && (num == 16'd0);
    assign param_byte = (state == com_pkg::WORK) && (num == 16'd1) &&
                        (btype == com_pkg::DPARAM);

    // second length byte and all data bytes go through the crc.
    assign crc_en  = (state == com_pkg::WORK) ||
                     ((state == com_pkg::DNUM) && (num >= len_last));
    assign crc_clr = (state == com_pkg::WAIT);
    assign crc_ok  = (com_rxd == crc_out);

    assign fs       = (state == com_pkg::DONE);
    assign data_cmd = {device_idx, data_idx, freq_samp, filt_up, filt_low, 12'h000};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= com_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            com_pkg::IDLE: next_state = com_pkg::WAIT;
            com_pkg::WAIT: begin
                if (com_rxd == com_pkg::PID_SYNC) next_state = com_pkg::RPID;
            end
            com_pkg::RPID: begin
                case (com_rxd)
                    com_pkg::PID_CMD: next_state = com_pkg::DNUM;
                    com_pkg::PID_ACK,
                    com_pkg::PID_NAK,
                    com_pkg::PID_STL: next_state = com_pkg::DONE;
                    default:          next_state = com_pkg::EROR;
                endcase
            end
            com_pkg::DNUM: begin
                if (num >= len_last) next_state = com_pkg::WORK;
            end
            com_pkg::WORK: begin
                if (num >= data_last) next_state = com_pkg::CRC5;
            end
            com_pkg::CRC5: next_state = com_pkg::DONE; // a bad check is flagged in btype.
            com_pkg::DONE: begin
                if (fd) next_state = com_pkg::WAIT;
            end
            com_pkg::EROR: next_state = com_pkg::DONE;
            default:       next_state = com_pkg::IDLE;
        endcase
    end

    // byte counter, restarts for each field.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            num <= 16'd0;
        end else if ((state == com_pkg::DNUM) && (num < len_last)) begin
            num <= num + 16'd1;
        end else if ((state == com_pkg::WORK) && (num < data_last)) begin
            num <= num + 16'd1;
        end else begin
            num <= 16'd0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ram_tlen <= 4'h0;
        end else if (state == com_pkg::WAIT) begin
            ram_tlen <= 4'h0;
        end else if ((state == com_pkg::DNUM) && (num == len_last)) begin
            ram_tlen <= com_rxd[3:0]; // low nibble of the second length byte.
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btype <= com_pkg::INIT;
        end else if (state == com_pkg::WAIT) begin
            btype <= com_pkg::INIT;
        end else if (state == com_pkg::RPID) begin
            case (com_rxd)
                com_pkg::PID_ACK: btype <= com_pkg::ACK;
                com_pkg::PID_NAK: btype <= com_pkg::NAK;
                com_pkg::PID_STL: btype <= com_pkg::STL;
                default: ;
            endcase
        end else if (head_byte) begin
            case (com_rxd[7:4])
                com_pkg::HEAD_DIDX:   btype <= com_pkg::DIDX;
                com_pkg::HEAD_DDIDX:  btype <= com_pkg::DDIDX;
                com_pkg::HEAD_DPARAM: btype <= com_pkg::DPARAM;
                default: ;                                  // unknown head stays init.
            endcase
        end else if ((state == com_pkg::CRC5) && !crc_ok) begin
            btype <= com_pkg::ERROR;
        end else if (state == com_pkg::EROR) begin
            btype <= com_pkg::ERROR;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            device_idx <= 4'h0;
            data_idx   <= 4'h0;
            freq_samp  <= 4'h0;
            filt_up    <= 4'h0;
            filt_low   <= 4'h0;
        end else if (state == com_pkg::WAIT) begin
            device_idx <= 4'h0;
            data_idx   <= 4'h0;
            freq_samp  <= 4'h0;
            filt_up    <= 4'h0;
            filt_low   <= 4'h0;
        end else if (head_byte) begin
            case (com_rxd[7:4])
                com_pkg::HEAD_DIDX:   device_idx <= com_rxd[3:0];
                com_pkg::HEAD_DDIDX:  data_idx   <= com_rxd[3:0];
                com_pkg::HEAD_DPARAM: freq_samp  <= com_rxd[3:0];
                default: ;
            endcase
        end else if (param_byte) begin
            filt_up  <= com_rxd[7:4];
            filt_low <= com_rxd[3:0];
        end
    end

    crc5 crc5_0 (
        .clk    (clk),
        .rst    (rst),
        .clear  (crc_clr),
        .enable (crc_en),
        .din    (com_rxd),
        .dout   (crc_out)
    );

endmodule

// File: rtl/resp_tx.sv
`timescale 1ns/1ps

module resp_tx (
    input  logic            clk,
    input  logic            rst,
    input  logic            fs,
    input  com_pkg::btype_e btype,
    output logic            fd,
    output logic [7:0]      com_txd,
    output logic            tx_en
);

    com_pkg::tx_state_e state;

    logic [7:0] pid_reg;
    logic [7:0] pid_sel;
    logic       has_reply;

    always_comb begin
        has_reply = 1'b1;
        pid_sel   = com_pkg::PID_NAK;
        case (btype)
            com_pkg::ERROR:  pid_sel = com_pkg::PID_NAK;
            com_pkg::DIDX,
            com_pkg::DDIDX,
            com_pkg::DPARAM: pid_sel = com_pkg::PID_ACK;
            com_pkg::INIT:   pid_sel = com_pkg::PID_STL; // command with unknown head.
            default:         has_reply = 1'b0;           // far-end handshakes get no answer.
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= com_pkg::T_IDLE;
        end else begin
            case (state)
                com_pkg::T_IDLE: begin
                    if (fs) state <= has_reply ? com_pkg::T_SYNC : com_pkg::T_END;
                end
                com_pkg::T_SYNC: state <= com_pkg::T_PID;
                com_pkg::T_PID:  state <= com_pkg::T_END;
                com_pkg::T_END: begin
                    if (!fs) state <= com_pkg::T_IDLE; // hold until the frame is released.
                end
                default: state <= com_pkg::T_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pid_reg <= 8'h00;
        end else if ((state == com_pkg::T_IDLE) && fs) begin
            pid_reg <= pid_sel;
        end
    end

    // fd lands in the pid cycle, or right away when there is nothing to send.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fd <= 1'b0;
        end else begin
            fd <= (state == com_pkg::T_SYNC) ||
                  ((state == com_pkg::T_IDLE) && fs && !has_reply);
        end
    end

    assign tx_en = (state == com_pkg::T_SYNC) || (state == com_pkg::T_PID);

    always_comb begin
        case (state)
            com_pkg::T_SYNC: com_txd = com_pkg::PID_SYNC;
            com_pkg::T_PID:  com_txd = pid_reg;
            default:         com_txd = 8'h00;
        endcase
    end

endmodule

// File: rtl/cmd_exec.sv
`timescale 1ns/1ps

module cmd_exec (
    input  logic            clk,
    input  logic            rst,
    input  logic            fs,
    input  logic            fd,
    input  com_pkg::btype_e btype,
    input  logic [31:0]     data_cmd,
    output logic [3:0]      device_idx,
    output logic [3:0]      data_idx,
    output logic [3:0]      freq_samp,
    output logic [3:0]      filt_up,
    output logic [3:0]      filt_low,
    output logic [7:0]      ack_cnt,
    output logic [7:0]      nak_cnt,
    output logic [7:0]      stl_cnt,
    output logic [7:0]      err_cnt
);

    logic commit;

    assign commit = fs && fd; // true for exactly one cycle per frame.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            device_idx <= 4'h0;
            data_idx   <= 4'h0;
            freq_samp  <= 4'h0;
            filt_up    <= 4'h0;
            filt_low   <= 4'h0;
        end else if (commit) begin
            case (btype)
                com_pkg::DIDX:  device_idx <= data_cmd[31:28];
                com_pkg::DDIDX: data_idx   <= data_cmd[27:24];
                com_pkg::DPARAM: begin
                    freq_samp <= data_cmd[23:20];
                    filt_up   <= data_cmd[19:16];
                    filt_low  <= data_cmd[15:12];
                end
                default: ;
            endcase
        end
    end

    // counters wrap at 8 bits.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_cnt <= 8'd0;
            nak_cnt <= 8'd0;
            stl_cnt <= 8'd0;
            err_cnt <= 8'd0;
        end else if (commit) begin
            case (btype)
                com_pkg::ACK:   ack_cnt <= ack_cnt + 8'd1;
                com_pkg::NAK:   nak_cnt <= nak_cnt + 8'd1;
                com_pkg::STL:   stl_cnt <= stl_cnt + 8'd1;
                com_pkg::ERROR: err_cnt <= err_cnt + 8'd1;
                default: ;
            endcase
        end
    end

endmodule

// File: rtl/com_link_top.sv
`timescale 1ns/1ps

module com_link_top (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] com_rxd,
    output logic [7:0] com_txd,
    output logic       tx_en,
    output logic [3:0] device_idx,
    output logic [3:0] data_idx,
    output logic [3:0] freq_samp,
    output logic [3:0] filt_up,
    output logic [3:0] filt_low,
    output logic [7:0] ack_cnt,
    output logic [7:0] nak_cnt,
    output logic [7:0] stl_cnt,
    output logic [7:0] err_cnt
);

    logic            fs;
    logic            fd;
    com_pkg::btype_e btype;
    logic [31:0]     data_cmd;

    com_rx com_rx_0 (
        .clk      (clk),
        .rst      (rst),
        .fd       (fd),
        .com_rxd  (com_rxd),
        .fs       (fs),
        .btype    (btype),
        .data_cmd (data_cmd)
    );

    resp_tx resp_tx_0 (
        .clk     (clk),
        .rst     (rst),
        .fs      (fs),
        .btype   (btype),
        .fd      (fd),
        .com_txd (com_txd),
        .tx_en   (tx_en)
    );

    cmd_exec cmd_exec_0 (
        .clk        (clk),
        .rst        (rst),
        .fs         (fs),
        .fd         (fd),
        .btype      (btype),
        .data_cmd   (data_cmd),
        .device_idx (device_idx),
        .data_idx   (data_idx),
        .freq_samp  (freq_samp),
        .filt_up    (filt_up),
        .filt_low   (filt_low),
        .ack_cnt    (ack_cnt),
        .nak_cnt    (nak_cnt),
        .stl_cnt    (stl_cnt),
        .err_cnt    (err_cnt)
    );

endmodule

// File: sim/com_link_tb.sv
`timescale 1ns/1ps

module com_link_tb;

    localparam int NUM_TESTS      = 14;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 40 + 200;
    localparam int IDLE_BYTES     = 8;

    localparam logic [7:0] P_SYN = 8'h01;
    localparam logic [7:0] P_CMD = 8'h1E;
    localparam logic [7:0] P_ACK = 8'h2D;
    localparam logic [7:0] P_NAK = 8'hA5;
    localparam logic [7:0] P_STL = 8'hE1;
    localparam logic [7:0] NONE  = 8'h00; // no reply expected.
    localparam logic [7:0] JUNK  = 8'h00; // entry sends bytes without a sync.

    localparam logic [4:0] CRC_INIT = 5'b11111;
    localparam logic [4:0] CRC_POLY = 5'b00101; // x^5 + x^2 + 1.

    logic       clk;
    logic       rst;
    logic [7:0] com_rxd;
    logic [7:0] com_txd;
    logic       tx_en;
    logic [3:0] device_idx;
    logic [3:0] data_idx;
    logic [3:0] freq_samp;
    logic [3:0] filt_up;
    logic [3:0] filt_low;
    logic [7:0] ack_cnt;
    logic [7:0] nak_cnt;
    logic [7:0] stl_cnt;
    logic [7:0] err_cnt;

    // stimulus table, one column per field.
    string       t_name  [NUM_TESTS];
    logic [7:0]  t_pid   [NUM_TESTS];
    logic [3:0]  t_head  [NUM_TESTS];
    logic [3:0]  t_val   [NUM_TESTS];
    logic [7:0]  t_byte2 [NUM_TESTS];
    logic [3:0]  t_len   [NUM_TESTS];
    bit          t_bad   [NUM_TESTS];
    logic [7:0]  t_reply [NUM_TESTS];
    logic [19:0] t_regs  [NUM_TESTS]; // device, data, freq, filt_up, filt_low.
    logic [31:0] t_cnts  [NUM_TESTS]; // ack, nak, stl, err.

    int          n_tests  = 0;
    int          errors   = 0;
    int          fd_count = 0;
    logic [31:0] lcg_state;
    logic [7:0]  tx_bytes[$];

    com_link_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .com_rxd    (com_rxd),
        .com_txd    (com_txd),
        .tx_en      (tx_en),
        .device_idx (device_idx),
        .data_idx   (data_idx),
        .freq_samp  (freq_samp),
        .filt_up    (filt_up),
        .filt_low   (filt_low),
        .ack_cnt    (ack_cnt),
        .nak_cnt    (nak_cnt),
        .stl_cnt    (stl_cnt),
        .err_cnt    (err_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reply bytes and frame-done pulses, sampled mid-cycle.
    always @(negedge clk) begin
        if (tx_en) begin
            tx_bytes.push_back(com_txd);
        end
        if (dut0.fd) begin
            fd_count++;
        end
    end

    function logic [7:0] next_rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    function automatic logic [4:0] crc5_byte(input logic [4:0] r, input logic [7:0] b);
        logic [4:0] c;
        logic       fb;
        c = r;
        for (int i = 0; i < 8; i++) begin
            fb = b[i] ^ c[4];
            c  = {c[3:0], 1'b0} ^ (fb ? CRC_POLY : 5'b00000);
        end
        return c;
    endfunction

    task automatic check(input string tname, input string field,
                         input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("error %s %s: expected %0h, actual %0h", tname, field, expected, actual);
        end
    endtask

    task automatic add_entry(input string name, input logic [7:0] pid, input logic [3:0] head,
                             input logic [3:0] val, input logic [7:0] byte2,
                             input logic [3:0] len, input bit bad, input logic [7:0] reply,
                             input logic [19:0] regs, input logic [31:0] cnts);
        t_name[n_tests]  = name;
        t_pid[n_tests]   = pid;
        t_head[n_tests]  = head;
        t_val[n_tests]   = val;
        t_byte2[n_tests] = byte2;
        t_len[n_tests]   = len;
        t_bad[n_tests]   = bad;
        t_reply[n_tests] = reply;
        t_regs[n_tests]  = regs;
        t_cnts[n_tests]  = cnts;
        n_tests++;
    endtask

    task automatic drive_byte(input logic [7:0] b);
        @(negedge clk);
        com_rxd = b;
    endtask

    task automatic send_packet(input int k);
        logic [7:0] pkt[$];
        logic [4:0] crc;
        crc = CRC_INIT;
        if (t_pid[k] == JUNK) begin
            for (int i = 0; i < t_len[k]; i++) begin
                pkt.push_back(next_rand_byte() | 8'h80); // never a sync byte.
            end
        end else begin
            pkt.push_back(P_SYN);
            pkt.push_back(t_pid[k]);
            if (t_pid[k] == P_CMD) begin
                pkt.push_back(8'h00);
                pkt.push_back({4'h0, t_len[k]});
                pkt.push_back({t_head[k], t_val[k]});
                if (t_len[k] > 1) begin
                    pkt.push_back(t_byte2[k]);
                end
                for (int i = 2; i < t_len[k]; i++) begin
                    pkt.push_back(next_rand_byte());
                end
                for (int i = 3; i < pkt.size(); i++) begin
                    crc = crc5_byte(crc, pkt[i]);
                end
                pkt.push_back({3'b000, ~crc} ^ (t_bad[k] ? 8'h04 : 8'h00));
            end
        end
        foreach (pkt[i]) begin
            drive_byte(pkt[i]);
        end
        repeat (IDLE_BYTES) drive_byte(8'h00);
    endtask

    task automatic run_test(input int k);
        int frames_before;
        frames_before = fd_count;
        send_packet(k);
        @(posedge clk);
        check(t_name[k], "frames", (t_pid[k] == JUNK) ? 0 : 1, fd_count - frames_before);
        if (t_reply[k] == NONE) begin
            check(t_name[k], "reply length", 0, tx_bytes.size());
        end else begin
            check(t_name[k], "reply length", 2, tx_bytes.size());
            if (tx_bytes.size() == 2) begin
                check(t_name[k], "reply sync", P_SYN, tx_bytes[0]);
                check(t_name[k], "reply pid", t_reply[k], tx_bytes[1]);
            end
        end
        check(t_name[k], "registers", t_regs[k],
              {device_idx, data_idx, freq_samp, filt_up, filt_low});
        check(t_name[k], "counters", t_cnts[k], {ack_cnt, nak_cnt, stl_cnt, err_cnt});
        tx_bytes.delete();
    endtask

    task automatic build_table();
        add_entry("didx",       P_CMD, 4'h9, 4'h3, 8'h00, 4'd1,  0, P_ACK, 20'h30000, 32'h00000000);
        add_entry("ddidx",      P_CMD, 4'h1, 4'h6, 8'h00, 4'd1,  0, P_ACK, 20'h36000, 32'h00000000);
        add_entry("dparam",     P_CMD, 4'h5, 4'hA, 8'hC4, 4'd2,  0, P_ACK, 20'h36AC4, 32'h00000000);
        add_entry("dparam_bad", P_CMD, 4'h5, 4'h2, 8'h37, 4'd2,  1, P_NAK, 20'h36AC4, 32'h00000001);
        add_entry("head_unkn",  P_CMD, 4'h3, 4'h7, 8'h00, 4'd1,  0, P_STL, 20'h36AC4, 32'h00000001);
        add_entry("far_ack",    P_ACK, 4'h0, 4'h0, 8'h00, 4'd0,  0, NONE,  20'h36AC4, 32'h01000001);
        add_entry("far_nak",    P_NAK, 4'h0, 4'h0, 8'h00, 4'd0,  0, NONE,  20'h36AC4, 32'h01010001);
        add_entry("far_stl",    P_STL, 4'h0, 4'h0, 8'h00, 4'd0,  0, NONE,  20'h36AC4, 32'h01010101);
        add_entry("pid_unkn",   8'h77, 4'h0, 4'h0, 8'h00, 4'd0,  0, P_NAK, 20'h36AC4, 32'h01010102);
        add_entry("len2",       P_CMD, 4'h9, 4'h5, 8'h6B, 4'd2,  0, P_ACK, 20'h56AC4, 32'h01010102);
        add_entry("len7",       P_CMD, 4'h1, 4'h9, 8'h5A, 4'd7,  0, P_ACK, 20'h59AC4, 32'h01010102);
        add_entry("len15",      P_CMD, 4'h5, 4'h1, 8'h8E, 4'd15, 0, P_ACK, 20'h5918E, 32'h01010102);
        add_entry("garbage",    JUNK,  4'h0, 4'h0, 8'h00, 4'd6,  0, NONE,  20'h5918E, 32'h01010102);
        add_entry("after_junk", P_CMD, 4'h9, 4'hC, 8'h21, 4'd3,  0, P_ACK, 20'hC918E, 32'h01010102);
    endtask

    initial begin
        rst       = 1'b1;
        com_rxd   = 8'h00;
        lcg_state = 32'h87623eef;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        check("reset", "tx_en", 0, tx_en);
        check("reset", "com_txd", 0, com_txd);
        check("reset", "registers", 0, {device_idx, data_idx, freq_samp, filt_up, filt_low});
        check("reset", "counters", 0, {ack_cnt, nak_cnt, stl_cnt, err_cnt});
        for (int k = 0; k < n_tests; k++) begin
            run_test(k);
        end
        $display("%0d tests run, %0d errors", n_tests, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

// File: sim.f
rtl/com_pkg.sv
rtl/crc5.sv
rtl/com_rx.sv
rtl/resp_tx.sv
rtl/cmd_exec.sv
rtl/com_link_top.sv
sim/com_link_tb.sv

// File: Bender.yml
package:
  name: com_link

sources:
  - rtl/com_pkg.sv
  - rtl/crc5.sv
  - rtl/com_rx.sv
  - rtl/resp_tx.sv
  - rtl/cmd_exec.sv
  - rtl/com_link_top.sv
  - target: simulation
    files:
      - sim/com_link_tb.sv
